//--- verilog.f
+incdir+logic
logic/shift_pkg.sv
logic/shift_ctrl_if.sv
logic/shift_decode.sv
logic/shift_lanes.sv
logic/shift_round.sv
logic/shift_result.sv
logic/vshift_unit.sv
verification/vshift_unit_chk.sv
verification/vshift_unit_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert
TOP       = vshift_unit_tb
FILE_LIST = verilog.f
BUILD_DIR = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
FAIL_MSG  = TESTS FAILED
PASS_MSG  = TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/vshift_unit_tb.sv
`include "shift_cfg.svh"
`default_nettype none

module vshift_unit_tb;
  import shift_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int PLAIN_RANDOM = 60;
  localparam int SCALE_RANDOM = 10;
  localparam int CLIP_RANDOM = 48;
  localparam int MIXED_CYCLES = 64;
  // 1 + 12 + 16 + 16 directed micro-ops
  localparam int NUM_UOPS = 45 + PLAIN_RANDOM + 8 * SCALE_RANDOM + CLIP_RANDOM + MIXED_CYCLES;
  localparam int CYCLE_LIMIT = NUM_UOPS + RESET_CYCLES + 200;

  // values on the edge of each rounding mode
  localparam logic [`VLEN-1:0] HALFWAY = 128'h0003_0005_0006_000a_fffd_fffb_8001_7ffe;
  localparam logic [`VLEN-1:0] SMALL = 128'h0012_0034_0056_0078_0001_0000_007f_0040;
  localparam logic [`VLEN-1:0] EXTREME = 128'h7fff_8000_ffff_0100_8000_0000_7fff_ff80;

  typedef struct packed {
    logic [5:0]                  funct6;
    logic [2:0]                  funct3;
    logic [1:0]                  eew;
    logic [1:0]                  vxrm;
    logic [`VLEN-1:0]            vs1;
    logic [`VLEN-1:0]            vs2;
    logic [`XLEN-1:0]            rs1;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
    logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
    logic [31:0]                 issue_cycle;
  } uop_t;

  logic                        clk;
  logic                        reset;
  logic                        uop_valid;
  shift_funct6_e               funct6;
  shift_funct3_e               funct3;
  eew_e                        vs2_eew;
  vxrm_e                       vxrm;
  logic [`VLEN-1:0]            vs1_data;
  logic [`VLEN-1:0]            vs2_data;
  logic [`XLEN-1:0]            rs1_data;
  logic [`UOP_INDEX_WIDTH-1:0] uop_index;
  logic [`ROB_DEPTH_WIDTH-1:0] rob_entry;
  logic                        result_valid;
  logic [`ROB_DEPTH_WIDTH-1:0] result_rob_entry;
  logic [`VLEN-1:0]            result_data;
  logic                        result_vxsat;

  uop_t                        pending[$];
  int                          errors = 0;
  int                          checks = 0;
  int                          cycle_count = 0;
  logic [`ROB_DEPTH_WIDTH-1:0] next_tag = '0;

  vshift_unit i_vshift_unit (.*);

  bind vshift_unit vshift_unit_chk i_chk (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic is_legal(input logic [5:0] f6, input logic [2:0] f3);
    return (f6 inside {VSLL, VSRL, VSRA, VSSRL, VSSRA, VNCLIPU, VNCLIP}) &&
           (f3 == OPIVV || f3 == OPIVX);
  endfunction

  // {clipped, element} for one source element of width w
  function automatic logic [32:0] element_result(input logic [5:0] f6, input int w,
                                                 input logic [31:0] x, input int s,
                                                 input logic [1:0] rm);
    longint mask;
    longint v;
    longint q;
    logic   top;
    logic   rest;
    logic   inc;
    int     n;

    n    = w / 2;
    mask = (longint'(1) << w) - 1;
    v    = longint'(x) & mask;
    if ((f6 == VSRA || f6 == VSSRA || f6 == VNCLIP) && x[w-1]) begin
      v = v - (mask + 1);
    end
    if (f6 == VSLL) begin
      return {1'b0, 32'((v << s) & mask)};
    end
    q    = v >>> s;
    top  = (s > 0) ? v[s-1] : 1'b0;
    rest = (s > 1) ? ((v & ((longint'(1) << (s - 1)) - 1)) != 0) : 1'b0;
    case (rm)
      RNU:     inc = top;
      RNE:     inc = top & (rest | q[0]);
      RDN:     inc = 1'b0;
      default: inc = ~q[0] & (top | rest);
    endcase
    if (f6 == VSRL || f6 == VSRA) begin
      return {1'b0, 32'(q & mask)};
    end
    q = q + longint'(inc);
    if (f6 == VSSRL || f6 == VSSRA) begin
      return {1'b0, 32'(q & mask)};
    end
    if (f6 == VNCLIPU) begin
      if (q > (longint'(1) << n) - 1) begin
        return {1'b1, 32'((longint'(1) << n) - 1)};
      end
    end else if (q > (longint'(1) << (n - 1)) - 1) begin
      return {1'b1, 32'((longint'(1) << (n - 1)) - 1)};
    end else if (q < -(longint'(1) << (n - 1))) begin
      return {1'b1, 32'(longint'(1) << (n - 1))};
    end
    return {1'b0, 32'(q)};
  endfunction

  // {vxsat, data}
  function automatic logic [`VLEN:0] compute_expected(input uop_t u);
    logic [`VLEN-1:0] data;
    logic [31:0]      amt_src;
    logic [32:0]      elem;
    logic             sat;
    logic             clip;
    int               w;
    int               amount;

    data = '0;
    sat  = 1'b0;
    clip = u.funct6 == VNCLIPU || u.funct6 == VNCLIP;
    w    = (u.eew == EEW32) ? 32 : 16;
    for (int i = 0; i < `VLEN / w; i++) begin
      amt_src = (u.funct3 == OPIVX) ? u.rs1 : 32'(u.vs1 >> (i * w));
      amount  = int'(amt_src & 32'(w - 1));
      elem    = element_result(u.funct6, w, 32'(u.vs2 >> (i * w)), amount, u.vxrm);
      sat     = sat | elem[32];
      if (w == 32) begin
        if (clip) begin
          data[i*16 +: 16] = elem[15:0];
        end else begin
          data[i*32 +: 32] = elem[31:0];
        end
      end else begin
        if (clip) begin
          data[i*8 +: 8] = elem[7:0];
        end else begin
          data[i*16 +: 16] = elem[15:0];
        end
      end
    end
    if (clip && u.uop_index[0]) begin
      data = data << (`VLEN / 2);
    end
    return {sat, data};
  endfunction

  task automatic check_value(input string name, input logic [`VLEN-1:0] got,
                             input logic [`VLEN-1:0] expected);
    checks++;
    assert (got === expected) else begin
      $display("mismatch at time %0t: %s got %h expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #2;
    uop_valid = 1'b0;
  endtask

  task automatic drive_uop(input uop_t u);
    @(posedge clk);
    #2;
    u.rob_entry = next_tag;
    next_tag++;
    uop_valid = 1'b1;
    funct6    = shift_funct6_e'(u.funct6);
    funct3    = shift_funct3_e'(u.funct3);
    vs2_eew   = eew_e'(u.eew);
    vxrm      = vxrm_e'(u.vxrm);
    vs1_data  = u.vs1;
    vs2_data  = u.vs2;
    rs1_data  = u.rs1;
    uop_index = u.uop_index;
    rob_entry = u.rob_entry;
    if (is_legal(u.funct6, u.funct3)) begin
      u.issue_cycle = 32'(cycle_count);
      pending.push_back(u);
    end
  endtask

  task automatic issue_random(input logic [5:0] f6, input logic [1:0] rm);
    uop_t u;
    u           = '0;
    u.funct6    = f6;
    u.funct3    = ($urandom_range(1) == 1) ? OPIVX : OPIVV;
    u.eew       = ($urandom_range(1) == 1) ? EEW32 : EEW16;
    u.vxrm      = rm;
    u.vs1       = {$urandom, $urandom, $urandom, $urandom};
    u.vs2       = {$urandom, $urandom, $urandom, $urandom};
    u.rs1       = $urandom;
    u.uop_index = 3'($urandom);
    drive_uop(u);
  endtask

  // scalar amount with random upper bits in rs1
  task automatic issue_scalar(input logic [5:0] f6, input logic [1:0] eew,
                              input logic [1:0] rm, input logic [`VLEN-1:0] vs2,
                              input int amount, input logic high);
    uop_t u;
    u           = '0;
    u.funct6    = f6;
    u.funct3    = OPIVX;
    u.eew       = eew;
    u.vxrm      = rm;
    u.vs1       = {$urandom, $urandom, $urandom, $urandom};
    u.vs2       = vs2;
    u.rs1       = ($urandom & ~32'h1f) | 32'(amount);
    u.uop_index = {2'b00, high};
    drive_uop(u);
  endtask

  task automatic issue_illegal();
    uop_t u;
    u        = '0;
    u.funct3 = OPIVV;
    u.eew    = EEW16;
    u.vs2    = {$urandom, $urandom, $urandom, $urandom};
    case ($urandom_range(3))
      0: u.funct6 = 6'b101100;
      1: u.funct6 = 6'b101101;
      2: u.funct6 = 6'b000000;
      default: begin
        // immediate form is not a separate source here
        u.funct6 = VSRL;
        u.funct3 = 3'b011;
      end
    endcase
    drive_uop(u);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    idle_cycle();
    while (pending.size() > 0) begin
      idle_cycle();
    end
    idle_cycle();
    $display("%s: %s, %0d errors", name, (errors == errors_before) ? "ok" : "failed",
             errors - errors_before);
  endtask

  // compares each result against the oldest outstanding micro-op
  initial begin : compare
    uop_t           u;
    logic [`VLEN:0] expected;
    forever begin
      @(negedge clk);
      if (result_valid === 1'b1) begin
        assert (pending.size() > 0) else begin
          $display("unexpected result at time %0t with no micro-op outstanding", $time);
          errors++;
        end
        if (pending.size() > 0) begin
          u        = pending.pop_front();
          expected = compute_expected(u);
          check_value("result_data", result_data, expected[`VLEN-1:0]);
          check_value("result_vxsat", 128'(result_vxsat), 128'(expected[`VLEN]));
          check_value("result_rob_entry", 128'(result_rob_entry), 128'(u.rob_entry));
          check_value("result latency", 128'(cycle_count), 128'(u.issue_cycle + 1));
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles, %0d results outstanding", cycle_count, pending.size());
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [5:0] plain_ops[3];
    logic [1:0] widths[2];
    int         mark;
    int         pick;

    plain_ops = '{VSLL, VSRL, VSRA};
    widths    = '{EEW16, EEW32};
    void'($urandom(32'h10d1));
    reset     = 1'b1;
    // a saturating clip held during reset must not reach the outputs
    uop_valid = 1'b1;
    funct6    = VNCLIPU;
    funct3    = OPIVX;
    vs2_eew   = EEW16;
    vxrm      = RNU;
    vs1_data  = '0;
    vs2_data  = EXTREME;
    rs1_data  = '0;
    uop_index = '0;
    rob_entry = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    reset     = 1'b0;
    uop_valid = 1'b0;

    mark = errors;
    repeat (4) begin
      idle_cycle();
      checks++;
      assert (result_valid === 1'b0 && result_vxsat === 1'b0) else begin
        $display("result_valid or result_vxsat high at time %0t before any micro-op", $time);
        errors++;
      end
    end
    issue_scalar(VSLL, EEW32, RNU, SMALL, 3, 1'b0);
    finish_test("test 1 reset and latency", mark);

    mark = errors;
    repeat (PLAIN_RANDOM) issue_random(plain_ops[$urandom_range(2)], 2'($urandom));
    foreach (plain_ops[k]) begin
      for (int e = 0; e < 2; e++) begin
        issue_scalar(plain_ops[k], widths[e], RNU, {$urandom, $urandom, $urandom, $urandom},
                     0, 1'b0);
        issue_scalar(plain_ops[k], widths[e], RNU, {$urandom, $urandom, $urandom, $urandom},
                     (e == 1) ? 31 : 15, 1'b0);
      end
    end
    finish_test("test 2 single-width shifts", mark);

    mark = errors;
    for (int m = 0; m < 4; m++) begin
      repeat (SCALE_RANDOM) begin
        issue_random(VSSRL, 2'(m));
        issue_random(VSSRA, 2'(m));
      end
      for (int e = 0; e < 2; e++) begin
        issue_scalar(VSSRA, widths[e], 2'(m), HALFWAY, 1, 1'b0);
        issue_scalar(VSSRL, widths[e], 2'(m), HALFWAY, 2, 1'b0);
      end
    end
    finish_test("test 3 scaling shifts", mark);

    mark = errors;
    repeat (CLIP_RANDOM / 2) begin
      issue_random(VNCLIPU, 2'($urandom));
      issue_random(VNCLIP, 2'($urandom));
    end
    for (int e = 0; e < 2; e++) begin
      for (int h = 0; h < 2; h++) begin
        issue_scalar(VNCLIPU, widths[e], RNU, SMALL, (e == 1) ? 16 : 0, h[0]);
        issue_scalar(VNCLIP, widths[e], RNU, SMALL, (e == 1) ? 16 : 0, h[0]);
        issue_scalar(VNCLIPU, widths[e], RNE, EXTREME, 0, h[0]);
        issue_scalar(VNCLIP, widths[e], RNE, EXTREME, 0, h[0]);
      end
    end
    finish_test("test 4 narrowing clips", mark);

    mark = errors;
    for (int c = 0; c < MIXED_CYCLES; c++) begin
      pick = int'($urandom_range(9));
      if (pick < 2) begin
        idle_cycle();
      end else if (pick < 4) begin
        issue_illegal();
      end else begin
        issue_random(plain_ops[$urandom_range(2)] | 6'(pick > 6 ? 6'b000010 : 6'b0),
                     2'($urandom));
      end
    end
    finish_test("test 5 back-to-back mix", mark);

    errors += i_vshift_unit.i_chk.error_count;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/vshift_unit_chk.sv
`default_nettype none

module vshift_unit_chk (
  input logic                     clk,
  input logic                     reset,
  input logic                     uop_valid,
  input shift_pkg::shift_funct6_e funct6,
  input shift_pkg::shift_funct3_e funct3,
  input logic                     result_valid,
  input logic                     result_vxsat
);
  import shift_pkg::*;

  int   error_count = 0;
  logic legal_uop;

  assign legal_uop = uop_valid &&
                     (funct6 inside {VSLL, VSRL, VSRA, VSSRL, VSSRA, VNCLIPU, VNCLIP}) &&
                     (funct3 inside {OPIVV, OPIVX});

  // one result one cycle after each legal micro-op
  result_follows_issue: assert property (
    @(posedge clk) disable iff (reset) legal_uop |=> result_valid
  ) else begin
    $error("legal micro-op produced no result");
    error_count++;
  end

  no_result_without_issue: assert property (
    @(posedge clk) disable iff (reset) !legal_uop |=> !result_valid
  ) else begin
    $error("result without a legal micro-op");
    error_count++;
  end

  vxsat_needs_valid: assert property (
    @(posedge clk) disable iff (reset) result_vxsat |-> result_valid
  ) else begin
    $error("vxsat raised without a result");
    error_count++;
  end

  quiet_in_reset: assert property (
    @(posedge clk) reset |=> !result_valid && !result_vxsat
  ) else begin
    $error("outputs active during reset");
    error_count++;
  end

endmodule

`default_nettype wire

//--- logic/vshift_unit.sv
`include "shift_cfg.svh"
`default_nettype none

module vshift_unit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         uop_valid,
  input  shift_pkg::shift_funct6_e     funct6,
  input  shift_pkg::shift_funct3_e     funct3,
  input  shift_pkg::eew_e              vs2_eew,
  input  shift_pkg::vxrm_e             vxrm,
  input  logic [`VLEN-1:0]             vs1_data,
  input  logic [`VLEN-1:0]             vs2_data,
  input  logic [`XLEN-1:0]             rs1_data,
  input  logic [`UOP_INDEX_WIDTH-1:0]  uop_index,
  input  logic [`ROB_DEPTH_WIDTH-1:0]  rob_entry,
  output logic                         result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0]  result_rob_entry,
  output logic [`VLEN-1:0]             result_data,
  output logic                         result_vxsat
);

  logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] lane16_value;
  logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] lane16_round_bits;
  logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   lane32_value;
  logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   lane32_round_bits;
  logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] rounded16;
  logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   rounded32;
  logic [`VLEN/`HWORD_WIDTH-1:0]                  carry16;
  logic [`VLEN/`WORD_WIDTH-1:0]                   carry32;

  shift_ctrl_if i_ctrl ();

  shift_decode i_decode (
    .uop_valid (uop_valid),
    .funct6    (funct6),
    .funct3    (funct3),
    .eew       (vs2_eew),
    .vxrm      (vxrm),
    .uop_index (uop_index),
    .rob_entry (rob_entry),
    .ctrl      (i_ctrl.decoder)
  );

  shift_lanes i_lanes (
    .vs1_data          (vs1_data),
    .vs2_data          (vs2_data),
    .rs1_data          (rs1_data),
    .ctrl              (i_ctrl.lanes),
    .lane16_value      (lane16_value),
    .lane16_round_bits (lane16_round_bits),
    .lane32_value      (lane32_value),
    .lane32_round_bits (lane32_round_bits)
  );

  shift_round i_round (
    .lane16_value      (lane16_value),
    .lane16_round_bits (lane16_round_bits),
    .lane32_value      (lane32_value),
    .lane32_round_bits (lane32_round_bits),
    .ctrl              (i_ctrl.rounding),
    .rounded16         (rounded16),
    .rounded32         (rounded32),
    .carry16           (carry16),
    .carry32           (carry32)
  );

  shift_result i_result (
    .clk              (clk),
    .reset            (reset),
    .lane16_value     (lane16_value),
    .lane32_value     (lane32_value),
    .rounded16        (rounded16),
    .rounded32        (rounded32),
    .carry16          (carry16),
    .carry32          (carry32),
    .ctrl             (i_ctrl.result),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data),
    .result_vxsat     (result_vxsat)
  );

endmodule

`default_nettype wire

//--- logic/shift_result.sv
`include "shift_cfg.svh"
`default_nettype none

module shift_result (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] lane16_value,
  input  logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   lane32_value,
  input  logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] rounded16,
  input  logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   rounded32,
  input  logic [`VLEN/`HWORD_WIDTH-1:0]                  carry16,
  input  logic [`VLEN/`WORD_WIDTH-1:0]                   carry32,
  shift_ctrl_if.result                                   ctrl,
  output logic                                           result_valid,
  output logic [`ROB_DEPTH_WIDTH-1:0]                    result_rob_entry,
  output logic [`VLEN-1:0]                               result_data,
  output logic                                           result_vxsat
);
  import shift_pkg::*;

  localparam int N16 = `VLEN / `HWORD_WIDTH;
  localparam int N32 = `VLEN / `WORD_WIDTH;

  logic [N16-1:0][`BYTE_WIDTH-1:0]  clip16;
  logic [N32-1:0][`HWORD_WIDTH-1:0] clip32;
  logic [N16-1:0]                   clipped16;
  logic [N32-1:0]                   clipped32;
  logic [`VLEN/2-1:0]               narrow_data;
  logic [`VLEN-1:0]                 data_next;
  logic                             sat_next;

  // wide holds the rounded value with bit 32 as its sign
  // returns {clipped, saturated value in the low narrow bits}
  function automatic logic [`HWORD_WIDTH:0] f_clip(
    input logic                   sign_clip,
    input logic [`WORD_WIDTH:0]   wide,
    input int unsigned            narrow
  );
    logic [`WORD_WIDTH:0]    limit;
    logic [`HWORD_WIDTH-1:0] ones;
    logic [`HWORD_WIDTH-1:0] value;
    logic                    over;
    logic                    under;

    limit = {(`WORD_WIDTH+1){1'b1}} << (sign_clip ? narrow - 1 : narrow);
    ones  = {`HWORD_WIDTH{1'b1}} >> (`HWORD_WIDTH - narrow);
    over  = ((wide & limit) != '0) && !(sign_clip && wide[`WORD_WIDTH]);
    under = sign_clip && wide[`WORD_WIDTH] && ((wide & limit) != limit);
    value = wide[`HWORD_WIDTH-1:0];
    if (over) begin
      value = sign_clip ? ones >> 1 : ones;
    end else if (under) begin
      value = ~(ones >> 1);
    end
    return {over | under, value};
  endfunction

  for (genvar i = 0; i < N16; i++) begin : g_clip16
    logic [`WORD_WIDTH:0]  wide;
    logic [`HWORD_WIDTH:0] clip;

    assign wide = {{`HWORD_WIDTH{ctrl.sign_clip & carry16[i]}}, carry16[i], rounded16[i]};
    assign clip = f_clip(ctrl.sign_clip, wide, `BYTE_WIDTH);
    assign clip16[i]    = clip[`BYTE_WIDTH-1:0];
    assign clipped16[i] = clip[`HWORD_WIDTH];
  end

  for (genvar i = 0; i < N32; i++) begin : g_clip32
    logic [`HWORD_WIDTH:0] clip;

    assign clip = f_clip(ctrl.sign_clip, {carry32[i], rounded32[i]}, `HWORD_WIDTH);
    assign clip32[i]    = clip[`HWORD_WIDTH-1:0];
    assign clipped32[i] = clip[`HWORD_WIDTH];
  end

  always_comb begin
    data_next = '0;
    sat_next  = 1'b0;

    if (ctrl.eew == EEW32) begin
      narrow_data = clip32;
    end else begin
      narrow_data = clip16;
    end

    case (ctrl.op_class)
      CLASS_PLAIN: begin
        if (ctrl.eew == EEW32) begin
          data_next = lane32_value;
        end else begin
          data_next = lane16_value;
        end
      end
      CLASS_SCALE: begin
        if (ctrl.eew == EEW32) begin
          data_next = rounded32;
        end else begin
          data_next = rounded16;
        end
      end
      CLASS_CLIP: begin
        // other half stays zero
        if (ctrl.narrow_high) begin
          data_next[`VLEN-1 -: `VLEN/2] = narrow_data;
        end else begin
          data_next[`VLEN/2-1:0] = narrow_data;
        end
        sat_next = (ctrl.eew == EEW32) ? |clipped32 : |clipped16;
      end
      default: begin
        data_next = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      result_vxsat <= 1'b0;
    end else begin
      result_valid <= ctrl.issue_valid;
      result_vxsat <= ctrl.issue_valid & sat_next;
    end
  end

  always_ff @(posedge clk) begin
    result_data      <= data_next;
    result_rob_entry <= ctrl.rob_entry;
  end

endmodule

`default_nettype wire

//--- logic/shift_round.sv
`include "shift_cfg.svh"
`default_nettype none

module shift_round (
  input  logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] lane16_value,
  input  logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] lane16_round_bits,
  input  logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   lane32_value,
  input  logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   lane32_round_bits,
  shift_ctrl_if.rounding                                 ctrl,
  output logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] rounded16,
  output logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   rounded32,
  output logic [`VLEN/`HWORD_WIDTH-1:0]                  carry16,
  output logic [`VLEN/`WORD_WIDTH-1:0]                   carry32
);
  import shift_pkg::*;

  localparam int N16 = `VLEN / `HWORD_WIDTH;
  localparam int N32 = `VLEN / `WORD_WIDTH;

  logic sra;

  // top has half-lsb weight and rest covers the bits below it
  function automatic logic f_increment(input vxrm_e mode, input logic lsb,
                                       input logic top, input logic rest);
    case (mode)
      RNU:     return top;
      RNE:     return top & (rest | lsb);
      RDN:     return 1'b0;
      default: return ~lsb & (top | rest);
    endcase
  endfunction

  assign sra = ctrl.shift_op == SHIFT_SRA;

  for (genvar i = 0; i < N16; i++) begin : g_round16
    logic inc;

    assign inc = f_increment(ctrl.vxrm, lane16_value[i][0],
                             lane16_round_bits[i][`HWORD_WIDTH-1],
                             |lane16_round_bits[i][`HWORD_WIDTH-2:0]);
    assign {carry16[i], rounded16[i]} =
      {sra & lane16_value[i][`HWORD_WIDTH-1], lane16_value[i]} + (`HWORD_WIDTH+1)'(inc);
  end

  for (genvar i = 0; i < N32; i++) begin : g_round32
    logic inc;

    assign inc = f_increment(ctrl.vxrm, lane32_value[i][0],
                             lane32_round_bits[i][`WORD_WIDTH-1],
                             |lane32_round_bits[i][`WORD_WIDTH-2:0]);
    assign {carry32[i], rounded32[i]} =
      {sra & lane32_value[i][`WORD_WIDTH-1], lane32_value[i]} + (`WORD_WIDTH+1)'(inc);
  end

endmodule

`default_nettype wire

//--- logic/shift_lanes.sv
`include "shift_cfg.svh"
`default_nettype none

module shift_lanes (
  input  logic [`VLEN-1:0]                               vs1_data,
  input  logic [`VLEN-1:0]                               vs2_data,
  input  logic [`XLEN-1:0]                               rs1_data,
  shift_ctrl_if.lanes                                    ctrl,
  output logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] lane16_value,
  output logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0] lane16_round_bits,
  output logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   lane32_value,
  output logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]   lane32_round_bits
);
  import shift_pkg::*;

  localparam int N16 = `VLEN / `HWORD_WIDTH;
  localparam int N32 = `VLEN / `WORD_WIDTH;
  localparam int AMT16_WIDTH = $clog2(`HWORD_WIDTH);
  localparam int AMT32_WIDTH = $clog2(`WORD_WIDTH);
  // a 32-bit operand, its fraction field and one sign bit
  localparam int SHIFTER_WIDTH = 2 * `WORD_WIDTH + 1;

  logic [N16-1:0][`HWORD_WIDTH-1:0] src16;
  logic [N16-1:0][AMT16_WIDTH-1:0]  amt16;
  logic [N32-1:0][`WORD_WIDTH-1:0]  src32;
  logic [N32-1:0][AMT32_WIDTH-1:0]  amt32;
  logic                             sra;

  function automatic logic [SHIFTER_WIDTH-1:0] f_shift(
    input shift_op_e                       op,
    input logic signed [SHIFTER_WIDTH-1:0] src,
    input logic [AMT32_WIDTH-1:0]          amount
  );
    if (op == SHIFT_SLL) begin
      return src << amount;
    end
    return src >>> amount;
  endfunction

  assign sra = ctrl.shift_op == SHIFT_SRA;

  // idle width sees zero operands
  always_comb begin
    src16 = '0;
    amt16 = '0;
    src32 = '0;
    amt32 = '0;
    if (ctrl.eew == EEW32) begin
      for (int i = 0; i < N32; i++) begin
        src32[i] = vs2_data[i*`WORD_WIDTH +: `WORD_WIDTH];
        amt32[i] = ctrl.use_scalar ? rs1_data[AMT32_WIDTH-1:0]
                                   : vs1_data[i*`WORD_WIDTH +: AMT32_WIDTH];
      end
    end else begin
      for (int i = 0; i < N16; i++) begin
        src16[i] = vs2_data[i*`HWORD_WIDTH +: `HWORD_WIDTH];
        amt16[i] = ctrl.use_scalar ? rs1_data[AMT16_WIDTH-1:0]
                                   : vs1_data[i*`HWORD_WIDTH +: AMT16_WIDTH];
      end
    end
  end

  // operand sits above a field of zeros that catches shifted-out bits
  for (genvar i = 0; i < N16; i++) begin : g_lane16
    logic                     fill;
    logic [SHIFTER_WIDTH-1:0] shifted;

    assign fill    = sra & src16[i][`HWORD_WIDTH-1];
    assign shifted = f_shift(ctrl.shift_op,
                             {{(SHIFTER_WIDTH-2*`HWORD_WIDTH){fill}}, src16[i],
                              {`HWORD_WIDTH{1'b0}}},
                             AMT32_WIDTH'(amt16[i]));
    assign {lane16_value[i], lane16_round_bits[i]} = shifted[2*`HWORD_WIDTH-1:0];
  end

  for (genvar i = 0; i < N32; i++) begin : g_lane32
    logic                     fill;
    logic [SHIFTER_WIDTH-1:0] shifted;

    assign fill    = sra & src32[i][`WORD_WIDTH-1];
    assign shifted = f_shift(ctrl.shift_op,
                             {fill, src32[i], {`WORD_WIDTH{1'b0}}},
                             amt32[i]);
    assign {lane32_value[i], lane32_round_bits[i]} = shifted[2*`WORD_WIDTH-1:0];
  end

endmodule

`default_nettype wire

//--- logic/shift_decode.sv
`include "shift_cfg.svh"
`default_nettype none

module shift_decode (
  input  logic                         uop_valid,
  input  shift_pkg::shift_funct6_e     funct6,
  input  shift_pkg::shift_funct3_e     funct3,
  input  shift_pkg::eew_e              eew,
  input  shift_pkg::vxrm_e             vxrm,
  input  logic [`UOP_INDEX_WIDTH-1:0]  uop_index,
  input  logic [`ROB_DEPTH_WIDTH-1:0]  rob_entry,
  shift_ctrl_if.decoder                ctrl
);
  import shift_pkg::*;

  logic known_op;
  logic known_src;

  always_comb begin
    known_op       = 1'b1;
    ctrl.shift_op  = SHIFT_SLL;
    ctrl.op_class  = CLASS_PLAIN;
    ctrl.sign_clip = 1'b0;

    case (funct6)
      VSLL: begin
        ctrl.shift_op = SHIFT_SLL;
      end
      VSRL: begin
        ctrl.shift_op = SHIFT_SRL;
      end
      VSRA: begin
        ctrl.shift_op = SHIFT_SRA;
      end
      VSSRL: begin
        ctrl.shift_op = SHIFT_SRL;
        ctrl.op_class = CLASS_SCALE;
      end
      VSSRA: begin
        ctrl.shift_op = SHIFT_SRA;
        ctrl.op_class = CLASS_SCALE;
      end
      VNCLIPU: begin
        ctrl.shift_op = SHIFT_SRL;
        ctrl.op_class = CLASS_CLIP;
      end
      VNCLIP: begin
        ctrl.shift_op  = SHIFT_SRA;
        ctrl.op_class  = CLASS_CLIP;
        ctrl.sign_clip = 1'b1;
      end
      default: begin
        known_op = 1'b0;
      end
    endcase
  end

  assign known_src = (funct3 == OPIVV) || (funct3 == OPIVX);

  // only legal micro-ops ever produce a result
  assign ctrl.issue_valid = uop_valid & known_op & known_src;

  assign ctrl.eew         = eew;
  assign ctrl.vxrm        = vxrm;
  assign ctrl.use_scalar  = funct3 == OPIVX;
  assign ctrl.narrow_high = uop_index[0];
  assign ctrl.rob_entry   = rob_entry;

endmodule

`default_nettype wire

//--- logic/shift_ctrl_if.sv
`include "shift_cfg.svh"
`default_nettype none

interface shift_ctrl_if;
  logic                         issue_valid;
  shift_pkg::shift_op_e         shift_op;
  shift_pkg::op_class_e         op_class;
  logic                         sign_clip;
  shift_pkg::eew_e              eew;
  shift_pkg::vxrm_e             vxrm;
  logic                         use_scalar;
  logic                         narrow_high;
  logic [`ROB_DEPTH_WIDTH-1:0]  rob_entry;

  modport decoder (
    output issue_valid, shift_op, op_class, sign_clip, eew, vxrm,
    output use_scalar, narrow_high, rob_entry
  );

  modport lanes (input eew, shift_op, use_scalar);

  modport rounding (input vxrm, shift_op);

  modport result (input issue_valid, op_class, sign_clip, eew, narrow_high, rob_entry);
endinterface

`default_nettype wire

//--- logic/shift_pkg.sv
`default_nettype none

package shift_pkg;

  // funct6 codes of the supported shifts
  typedef enum logic [5:0] {
    VSLL    = 6'b100101,
    VSRL    = 6'b101000,
    VSRA    = 6'b101001,
    VSSRL   = 6'b101010,
    VSSRA   = 6'b101011,
    VNCLIPU = 6'b101110,
    VNCLIP  = 6'b101111
  } shift_funct6_e;

  // operand source with immediates arriving through rs1
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPIVX = 3'b100
  } shift_funct3_e;

  typedef enum logic [1:0] {
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  // fixed-point rounding modes
  typedef enum logic [1:0] {
    RNU = 2'b00,
    RNE = 2'b01,
    RDN = 2'b10,
    ROD = 2'b11
  } vxrm_e;

  typedef enum logic [1:0] {
    SHIFT_SLL = 2'b00,
    SHIFT_SRL = 2'b01,
    SHIFT_SRA = 2'b10
  } shift_op_e;

  // which result the unit returns
  typedef enum logic [1:0] {
    CLASS_PLAIN = 2'b00,
    CLASS_SCALE = 2'b01,
    CLASS_CLIP  = 2'b10
  } op_class_e;

endpackage

`default_nettype wire

//--- logic/shift_cfg.svh
`ifndef SHIFT_CFG_SVH
`define SHIFT_CFG_SVH

// vector register and scalar operand widths
`define VLEN 128
`define XLEN 32

// reorder buffer tag and micro-op index
`define ROB_DEPTH_WIDTH 4
`define UOP_INDEX_WIDTH 3

// element widths
`define BYTE_WIDTH 8
`define HWORD_WIDTH 16
`define WORD_WIDTH 32

`endif
